// File: src/dbg_pkg.sv
// debug unit package: widths, address map, cause codes, settings indices, enums
`default_nettype none

package dbg_pkg;

  // --------------------
  // widths
  localparam int DBG_ADDR_W = 15;  // debug bus address
  localparam int XLEN       = 32;
  localparam int CAUSE_W    = 6;

  localparam logic [CAUSE_W-1:0] CAUSE_HALT = 6'h1F;  // halt request or breakpoint

  // --------------------
  // address map
  typedef enum logic [5:0] {  // addr[13:8]
    REG_DBGA = 6'h00,  // debug registers, always accessible
    REG_GPR  = 6'h04,  // general purpose registers
    REG_DBGS = 6'h20   // npc/ppc, halted only for writes
  } region_e;

  typedef enum logic [5:0] {  // addr[7:2] inside REG_DBGA
    CTRL     = 6'h00,
    HIT      = 6'h01,
    IE       = 6'h02,
    CAUSE    = 6'h03,
    BP0_CTRL = 6'h10,
    BP0_DATA = 6'h11,
    BP1_CTRL = 6'h12,
    BP1_DATA = 6'h13
  } dbg_reg_e;

  typedef enum logic [1:0] {RD_NONE, RD_GPR, RD_DBGA, RD_DBGS} rdata_sel_e;

  typedef enum logic [2:0] {
    RUNNING, HALT_REQ, BP_HALT_REQ, HALT, BP_HALT, WAIT_RUNNING
  } halt_state_e;

  // --------------------
  // settings bus to the core
  localparam int SETS_W     = 5;
  localparam int SETS_SSTE  = 0;  // single step
  localparam int SETS_ECALL = 1;
  localparam int SETS_ELSU  = 2;  // load/store faults
  localparam int SETS_EBRK  = 3;
  localparam int SETS_EILL  = 4;

  // register bit positions
  localparam int CTRL_HALT_BIT  = 16;
  localparam int IE_ECALL_BIT   = 11;
  localparam int IE_ELSU_HI_BIT = 7;
  localparam int IE_ELSU_LO_BIT = 5;
  localparam int IE_EBRK_BIT    = 3;
  localparam int IE_EILL_BIT    = 2;

endpackage

`default_nettype wire

// File: src/dbg_acc_if.sv
// debug register access interface between bus decoder and register block
`timescale 1ns/1ns
`default_nettype none

interface dbg_acc_if;

  logic                     wr_en;   // one cycle write strobe
  dbg_pkg::dbg_reg_e        wr_idx;  // word index of the write
  logic [dbg_pkg::XLEN-1:0] wdata;
  dbg_pkg::dbg_reg_e        rd_idx;  // latched at grant
  logic [dbg_pkg::XLEN-1:0] rdata;   // comb from rd_idx

  // decoder side
  modport decode (
    output wr_en, wr_idx, wdata, rd_idx,
    input  rdata
  );

  // register block side
  modport regs (
    input  wr_en, wr_idx, wdata, rd_idx,
    output rdata
  );

endinterface

`default_nettype wire

// File: src/dbg_ctl_if.sv
// run control interface between register block and halt controller
`timescale 1ns/1ns
`default_nettype none

interface dbg_ctl_if;

  logic                        halt_cmd;    // pulse, ctrl write with halt bit
  logic                        resume_cmd;  // pulse, ctrl write without halt bit
  logic                        ssth_clear;  // pulse from hit write
  logic                        step_en;     // single step enabled
  logic                        bp_hit;      // any breakpoint matches
  logic                        halted;
  logic                        ssth;        // single step trap hit
  logic [dbg_pkg::CAUSE_W-1:0] cause;

  // --------------------
  // register block drives commands
  modport regs (
    output halt_cmd, resume_cmd, ssth_clear, step_en, bp_hit,
    input  halted, ssth, cause
  );

  // halt controller drives status
  modport ctrl (
    input  halt_cmd, resume_cmd, ssth_clear, step_en, bp_hit,
    output halted, ssth, cause
  );

endinterface

`default_nettype wire

// File: src/dbg_bus_decode.sv
// debug bus decoder: grant, rvalid, read mux, register file and jump requests
`timescale 1ns/1ns
`default_nettype none

module dbg_bus_decode #(
  parameter int REG_ADDR_WIDTH = 5
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           debug_req_i,
  input  logic                           debug_we_i,
  input  logic [dbg_pkg::DBG_ADDR_W-1:0] debug_addr_i,
  input  logic [dbg_pkg::XLEN-1:0]       debug_wdata_i,
  input  logic                           halted_i,
  input  logic [dbg_pkg::XLEN-1:0]       regfile_rdata_i,
  input  logic [dbg_pkg::XLEN-1:0]       pc_if_i,
  input  logic [dbg_pkg::XLEN-1:0]       pc_id_i,
  output logic                           debug_gnt_o,
  output logic                           debug_rvalid_o,
  output logic [dbg_pkg::XLEN-1:0]       debug_rdata_o,
  output logic                           regfile_rreq_o,
  output logic [REG_ADDR_WIDTH-1:0]      regfile_raddr_o,
  output logic                           regfile_wreq_o,
  output logic [REG_ADDR_WIDTH-1:0]      regfile_waddr_o,
  output logic [dbg_pkg::XLEN-1:0]       regfile_wdata_o,
  output logic                           jump_req_o,
  output logic [dbg_pkg::XLEN-1:0]       jump_addr_o,
  dbg_acc_if.decode                      acc
);

  dbg_pkg::region_e         region;
  dbg_pkg::rdata_sel_e      rdata_sel_n, rdata_sel_q;
  logic                     wr_req, rd_req;
  logic                     regfile_rreq_n;
  logic                     jump_req_n;
  logic [5:0]               addr_q;   // word index of the granted access
  logic [dbg_pkg::XLEN-1:0] wdata_q;  // jump target

  assign debug_gnt_o = debug_req_i;  // no back-pressure
  assign region      = dbg_pkg::region_e'(debug_addr_i[13:8]);
  // csr region (bit 14) is granted but does nothing
  assign wr_req = debug_req_i &  debug_we_i & ~debug_addr_i[14];
  assign rd_req = debug_req_i & ~debug_we_i & ~debug_addr_i[14];

  // --------------------
  // write path
  assign acc.wr_en  = wr_req & (region == dbg_pkg::REG_DBGA);
  assign acc.wr_idx = dbg_pkg::dbg_reg_e'(debug_addr_i[7:2]);
  assign acc.wdata  = debug_wdata_i;

  assign regfile_wreq_o  = wr_req & (region == dbg_pkg::REG_GPR) & halted_i;  // grant cycle
  assign regfile_waddr_o = debug_addr_i[REG_ADDR_WIDTH+1:2];
  assign regfile_wdata_o = debug_wdata_i;

  // npc write redirects the core
  assign jump_req_n = wr_req & (region == dbg_pkg::REG_DBGS) & halted_i
                      & (debug_addr_i[7:2] == 6'd0);

  // read source select
  always_comb begin
    rdata_sel_n    = dbg_pkg::RD_NONE;
    regfile_rreq_n = 1'b0;
    if (rd_req) begin
      unique case (region)
        dbg_pkg::REG_DBGA: rdata_sel_n = dbg_pkg::RD_DBGA;
        dbg_pkg::REG_DBGS: rdata_sel_n = dbg_pkg::RD_DBGS;
        dbg_pkg::REG_GPR: begin
          if (halted_i) begin  // gpr reads zero while running
            rdata_sel_n    = dbg_pkg::RD_GPR;
            regfile_rreq_n = 1'b1;
          end
        end
        default: ;  // unmapped, reads zero
      endcase
    end
  end

  // --------------------
  // grant stage flops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_rvalid_o <= 1'b0;
      rdata_sel_q    <= dbg_pkg::RD_NONE;
      regfile_rreq_o <= 1'b0;
      jump_req_o     <= 1'b0;
    end else begin
      debug_rvalid_o <= debug_gnt_o;     // always one cycle after gnt
      rdata_sel_q    <= rdata_sel_n;
      regfile_rreq_o <= regfile_rreq_n;  // pulses with rvalid
      jump_req_o     <= jump_req_n;
    end
  end

  always_ff @(posedge clk) begin
    if (debug_req_i) begin
      addr_q  <= debug_addr_i[7:2];
      wdata_q <= debug_wdata_i;
    end
  end

  assign acc.rd_idx      = dbg_pkg::dbg_reg_e'(addr_q);
  assign regfile_raddr_o = addr_q[REG_ADDR_WIDTH-1:0];
  assign jump_addr_o     = wdata_q;

  // read data mux, valid in the rvalid cycle
  always_comb begin
    debug_rdata_o = '0;
    unique case (rdata_sel_q)
      dbg_pkg::RD_GPR:  debug_rdata_o = regfile_rdata_i;  // core answers comb
      dbg_pkg::RD_DBGA: debug_rdata_o = acc.rdata;
      dbg_pkg::RD_DBGS: debug_rdata_o = addr_q[0] ? pc_id_i : pc_if_i;  // ppc : npc
      default: ;
    endcase
  end

  // --------------------
  a_rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    debug_gnt_o |=> debug_rvalid_o)
    else $error("rvalid missing one cycle after grant");

endmodule

`default_nettype wire

// File: src/dbg_regs.sv
// debug control/status registers, settings bits and breakpoint comparators
`timescale 1ns/1ns
`default_nettype none

module dbg_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       sleeping_i,
  input  logic [dbg_pkg::XLEN-1:0]   pc_if_i,
  input  logic                       branch_req_i,
  input  logic [dbg_pkg::XLEN-1:1]   branch_addr_i,
  output logic [dbg_pkg::SETS_W-1:0] settings_o,
  dbg_acc_if.regs                    acc,
  dbg_ctl_if.regs                    ctl
);

  logic [dbg_pkg::SETS_W-1:0] settings_q;
  logic [1:0]                 bp_en;
  logic [dbg_pkg::XLEN-1:1]   bp_addr [2];  // halfword aligned
  logic [1:0]                 bp_hit_vec;
  logic [dbg_pkg::XLEN-1:1]   comp_pc;
  logic                       ctrl_wr;

  assign ctrl_wr = acc.wr_en & (acc.wr_idx == dbg_pkg::CTRL);

  // --------------------
  // command pulses
  assign ctl.halt_cmd   = ctrl_wr &  acc.wdata[dbg_pkg::CTRL_HALT_BIT] & ~ctl.halted;
  assign ctl.resume_cmd = ctrl_wr & ~acc.wdata[dbg_pkg::CTRL_HALT_BIT] &  ctl.halted;
  assign ctl.ssth_clear = acc.wr_en & (acc.wr_idx == dbg_pkg::HIT) & acc.wdata[0];
  assign ctl.step_en    = settings_q[dbg_pkg::SETS_SSTE];
  assign settings_o     = settings_q;

  // settings and breakpoint enables
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      settings_q <= '0;
      bp_en      <= '0;
    end else if (acc.wr_en) begin
      unique case (acc.wr_idx)
        dbg_pkg::CTRL: settings_q[dbg_pkg::SETS_SSTE] <= acc.wdata[0];
        dbg_pkg::IE: begin
          settings_q[dbg_pkg::SETS_ECALL] <= acc.wdata[dbg_pkg::IE_ECALL_BIT];
          settings_q[dbg_pkg::SETS_ELSU]  <= acc.wdata[dbg_pkg::IE_ELSU_HI_BIT]
                                             | acc.wdata[dbg_pkg::IE_ELSU_LO_BIT];
          settings_q[dbg_pkg::SETS_EBRK]  <= acc.wdata[dbg_pkg::IE_EBRK_BIT];
          settings_q[dbg_pkg::SETS_EILL]  <= acc.wdata[dbg_pkg::IE_EILL_BIT];
        end
        dbg_pkg::BP0_CTRL: bp_en[0] <= acc.wdata[0];
        dbg_pkg::BP1_CTRL: bp_en[1] <= acc.wdata[0];
        default: ;  // hit handled as pulse
      endcase
    end
  end

  // breakpoint addresses, bit 0 dropped
  always_ff @(posedge clk) begin
    if (acc.wr_en && acc.wr_idx == dbg_pkg::BP0_DATA) begin
      bp_addr[0] <= acc.wdata[dbg_pkg::XLEN-1:1];
    end
    if (acc.wr_en && acc.wr_idx == dbg_pkg::BP1_DATA) begin
      bp_addr[1] <= acc.wdata[dbg_pkg::XLEN-1:1];
    end
  end

  // --------------------
  // comparators, branch target wins over fetch pc
  assign comp_pc = branch_req_i ? branch_addr_i : pc_if_i[dbg_pkg::XLEN-1:1];

  for (genvar i = 0; i < 2; i++) begin : g_bp
    assign bp_hit_vec[i] = bp_en[i] & (bp_addr[i] == comp_pc);
  end

  assign ctl.bp_hit = |bp_hit_vec;

  // read back, comb from latched index
  always_comb begin
    acc.rdata = '0;
    unique case (acc.rd_idx)
      dbg_pkg::CTRL: begin
        acc.rdata[dbg_pkg::CTRL_HALT_BIT] = ctl.halted;
        acc.rdata[0]                      = settings_q[dbg_pkg::SETS_SSTE];
      end
      dbg_pkg::HIT: begin
        acc.rdata[16] = sleeping_i;
        acc.rdata[0]  = ctl.ssth;
      end
      dbg_pkg::IE: begin
        acc.rdata[dbg_pkg::IE_ECALL_BIT]   = settings_q[dbg_pkg::SETS_ECALL];
        acc.rdata[dbg_pkg::IE_ELSU_HI_BIT] = settings_q[dbg_pkg::SETS_ELSU];  // both alias
        acc.rdata[dbg_pkg::IE_ELSU_LO_BIT] = settings_q[dbg_pkg::SETS_ELSU];
        acc.rdata[dbg_pkg::IE_EBRK_BIT]    = settings_q[dbg_pkg::SETS_EBRK];
        acc.rdata[dbg_pkg::IE_EILL_BIT]    = settings_q[dbg_pkg::SETS_EILL];
      end
      dbg_pkg::CAUSE: begin
        acc.rdata[dbg_pkg::XLEN-1] = ctl.cause[5];  // interrupt flag position
        acc.rdata[4:0]             = ctl.cause[4:0];
      end
      dbg_pkg::BP0_CTRL: acc.rdata = {bp_hit_vec[0], 30'b0, bp_en[0]};
      dbg_pkg::BP0_DATA: acc.rdata = {bp_addr[0], 1'b0};
      dbg_pkg::BP1_CTRL: acc.rdata = {bp_hit_vec[1], 30'b0, bp_en[1]};
      dbg_pkg::BP1_DATA: acc.rdata = {bp_addr[1], 1'b0};
      default: ;
    endcase
  end

  // hit write clears the step flag in the halt fsm
  a_ssth_clear: assert property (@(posedge clk) disable iff (!rst_n)
    ctl.ssth_clear |=> !ctl.ssth)
    else $error("single step hit not cleared by hit write");

endmodule

`default_nettype wire

// File: src/dbg_halt_ctrl.sv
// run/halt state machine with halt cause and single step status
`timescale 1ns/1ns
`default_nettype none

module dbg_halt_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        debug_halt_i,    // halt pin
  input  logic                        debug_resume_i,  // resume pin
  input  logic                        trap_i,
  input  logic [dbg_pkg::CAUSE_W-1:0] exc_cause_i,
  input  logic                        dbg_ack_i,       // core reached a safe point
  input  logic                        branch_req_i,
  output logic                        dbg_req_o,
  output logic                        stall_o,
  output logic                        halted_o,
  dbg_ctl_if.ctrl                     ctl
);

  dbg_pkg::halt_state_e        state_q, state_n;
  logic [dbg_pkg::CAUSE_W-1:0] cause_q, cause_n;
  logic                        ssth_q, ssth_n;
  logic                        resume;

  assign resume = ctl.resume_cmd | debug_resume_i;

  // --------------------
  // next state
  always_comb begin
    state_n   = state_q;
    cause_n   = cause_q;
    ssth_n    = ssth_q;
    dbg_req_o = 1'b0;
    stall_o   = 1'b0;
    halted_o  = 1'b0;

    unique case (state_q)
      dbg_pkg::RUNNING: begin
        ssth_n = 1'b0;
        if (ctl.halt_cmd | debug_halt_i | trap_i) begin
          dbg_req_o = 1'b1;
          state_n   = dbg_pkg::HALT_REQ;
          if (trap_i) begin
            ssth_n  = ctl.step_en;
            cause_n = exc_cause_i;
          end else begin
            cause_n = dbg_pkg::CAUSE_HALT;
          end
        end
        if (ctl.bp_hit) begin  // breakpoint wins
          dbg_req_o = 1'b1;
          state_n   = dbg_pkg::BP_HALT_REQ;
          cause_n   = dbg_pkg::CAUSE_HALT;
        end
      end
      dbg_pkg::HALT_REQ: begin
        dbg_req_o = 1'b1;  // held until ack
        if (dbg_ack_i) state_n = dbg_pkg::HALT;
        if (resume)    state_n = dbg_pkg::RUNNING;
      end
      dbg_pkg::BP_HALT_REQ: begin
        dbg_req_o = 1'b1;
        if (dbg_ack_i)               state_n = dbg_pkg::BP_HALT;
        if (resume || branch_req_i)  state_n = dbg_pkg::RUNNING;  // pc moved on
      end
      dbg_pkg::HALT, dbg_pkg::BP_HALT: begin
        halted_o = 1'b1;
        stall_o  = ~resume;  // stall drops in the resume cycle
        if (resume) begin
          state_n = (state_q == dbg_pkg::BP_HALT) ? dbg_pkg::WAIT_RUNNING : dbg_pkg::RUNNING;
        end
      end
      dbg_pkg::WAIT_RUNNING: begin
        ssth_n  = 1'b0;
        state_n = dbg_pkg::RUNNING;  // skip past the breakpoint pc
      end
      default: state_n = dbg_pkg::RUNNING;
    endcase

    if (ctl.ssth_clear) ssth_n = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= dbg_pkg::RUNNING;
      cause_q <= dbg_pkg::CAUSE_HALT;
      ssth_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      cause_q <= cause_n;
      ssth_q  <= ssth_n;
    end
  end

  assign ctl.halted = halted_o;
  assign ctl.ssth   = ssth_q;
  assign ctl.cause  = cause_q;

  // halted only after the core acknowledged the request
  a_halt_needs_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(halted_o) |-> $past(dbg_ack_i))
    else $error("halted without core acknowledge");

endmodule

`default_nettype wire

// File: src/dbg_unit_top.sv
// debug unit top level: plain ports, submodule instances and interface wiring
`timescale 1ns/1ns
`default_nettype none

module dbg_unit_top #(
  parameter int REG_ADDR_WIDTH = 5
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // --------------------
  // debug bus
  input  logic                           debug_req_i,
  output logic                           debug_gnt_o,
  output logic                           debug_rvalid_o,
  input  logic [dbg_pkg::DBG_ADDR_W-1:0] debug_addr_i,
  input  logic                           debug_we_i,
  input  logic [dbg_pkg::XLEN-1:0]       debug_wdata_i,
  output logic [dbg_pkg::XLEN-1:0]       debug_rdata_o,
  // run control
  input  logic                           debug_halt_i,
  input  logic                           debug_resume_i,
  output logic                           debug_halted_o,
  // core side
  output logic [dbg_pkg::SETS_W-1:0]     settings_o,
  input  logic                           trap_i,
  input  logic [dbg_pkg::CAUSE_W-1:0]    exc_cause_i,
  output logic                           stall_o,
  output logic                           dbg_req_o,
  input  logic                           dbg_ack_i,
  // register file ports
  output logic                           regfile_rreq_o,
  output logic [REG_ADDR_WIDTH-1:0]      regfile_raddr_o,
  input  logic [dbg_pkg::XLEN-1:0]       regfile_rdata_i,
  output logic                           regfile_wreq_o,
  output logic [REG_ADDR_WIDTH-1:0]      regfile_waddr_o,
  output logic [dbg_pkg::XLEN-1:0]       regfile_wdata_o,
  // pcs and breakpoints
  input  logic [dbg_pkg::XLEN-1:0]       pc_if_i,
  input  logic [dbg_pkg::XLEN-1:0]       pc_id_i,
  input  logic                           branch_req_i,
  input  logic [dbg_pkg::XLEN-1:1]       branch_addr_i,
  input  logic                           sleeping_i,
  output logic                           jump_req_o,
  output logic [dbg_pkg::XLEN-1:0]       jump_addr_o
);

  dbg_acc_if acc ();  // decoder to registers
  dbg_ctl_if ctl ();  // registers to halt fsm

  dbg_bus_decode #(.REG_ADDR_WIDTH(REG_ADDR_WIDTH)) u_decode (
    .clk, .rst_n, .debug_req_i, .debug_we_i, .debug_addr_i, .debug_wdata_i,
    .halted_i (debug_halted_o),
    .regfile_rdata_i, .pc_if_i, .pc_id_i, .debug_gnt_o, .debug_rvalid_o, .debug_rdata_o,
    .regfile_rreq_o, .regfile_raddr_o, .regfile_wreq_o, .regfile_waddr_o, .regfile_wdata_o,
    .jump_req_o, .jump_addr_o, .acc (acc.decode)
  );

  dbg_regs u_regs (
    .clk, .rst_n, .sleeping_i, .pc_if_i, .branch_req_i, .branch_addr_i, .settings_o,
    .acc (acc.regs), .ctl (ctl.regs)
  );

  dbg_halt_ctrl u_halt (
    .clk, .rst_n, .debug_halt_i, .debug_resume_i, .trap_i, .exc_cause_i, .dbg_ack_i,
    .branch_req_i, .dbg_req_o, .stall_o,
    .halted_o (debug_halted_o),
    .ctl      (ctl.ctrl)
  );

endmodule

`default_nettype wire

// File: verification/dbg_core_model.sv
// core stand-in: register file, delayed halt acknowledge, fetch/decode pc drive
`timescale 1ns/1ns
`default_nettype none

module dbg_core_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        dbg_req_i,
  output logic        dbg_ack_o,
  input  logic [4:0]  raddr_i,
  output logic [31:0] rdata_o,
  input  logic        wreq_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i,
  input  logic        jump_req_i,
  input  logic [31:0] jump_addr_i,
  input  logic        pc_load_i,  // testbench moves the fetch pc
  input  logic [31:0] pc_val_i,
  output logic [31:0] pc_if_o,
  output logic [31:0] pc_id_o
);

  logic [31:0] gpr [32];
  logic [1:0]  delay_q;  // cycles left before ack
  logic        armed_q;

  assign rdata_o = gpr[raddr_i];  // comb read port
  assign pc_id_o = pc_if_o - 32'd4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        gpr[i] <= 32'h5a5a_0000 + i * 32'h0000_0101;  // fill from whole index
      end
      dbg_ack_o <= 1'b0;
      delay_q   <= '0;
      armed_q   <= 1'b0;
      pc_if_o   <= 32'h0000_0200;
    end else begin
      if (wreq_i) gpr[waddr_i] <= wdata_i;
      if (jump_req_i) pc_if_o <= jump_addr_i;  // debugger redirect
      else if (pc_load_i) pc_if_o <= pc_val_i;
      // ack 1 to 4 cycles after the request is seen
      dbg_ack_o <= 1'b0;
      if (dbg_req_i && !dbg_ack_o) begin
        if (!armed_q) begin
          armed_q <= 1'b1;
          delay_q <= 2'($urandom_range(3, 0));
        end else if (delay_q == 2'd0) begin
          dbg_ack_o <= 1'b1;
          armed_q   <= 1'b0;
        end else begin
          delay_q <= delay_q - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_dbg_unit.sv
// testbench for the debug unit: clock, reset, bus stimulus, assertions, timeout
`timescale 1ns/1ns
`default_nettype none

module tb_dbg_unit;

  localparam int MAX_CYCLES = 2000;
  // bus addresses, region in bits 13:8, word index in bits 7:2
  localparam logic [14:0] A_CTRL = 15'h0000,
                          A_HIT = 15'h0004,
                          A_IE = 15'h0008,
                          A_CAUSE = 15'h000C,
                          A_BP0_CTRL = 15'h0040,
                          A_BP0_DATA = 15'h0044,
                          A_BP1_CTRL = 15'h0048,
                          A_BP1_DATA = 15'h004C,
                          A_GPR5 = 15'h0414,
                          A_NPC = 15'h2000,
                          A_PPC = 15'h2004;

  logic clk = 1'b0;
  logic rst_n, debug_req, debug_gnt, debug_rvalid, debug_we;
  logic [14:0] debug_addr;
  logic [31:0] debug_wdata, debug_rdata, regfile_rdata, regfile_wdata;
  logic debug_halt, debug_resume, debug_halted, trap, stall, dbg_req, dbg_ack;
  logic [4:0] settings, regfile_raddr, regfile_waddr;
  logic [5:0] exc_cause;
  logic regfile_rreq, regfile_wreq, branch_req, sleeping, jump_req, pc_load;
  logic [31:0] pc_if, pc_id, jump_addr, pc_val;
  logic [31:1] branch_addr;
  int cycle_cnt = 0;

  always #50 clk = ~clk;

  dbg_unit_top #(.REG_ADDR_WIDTH(5)) UUT (
    .clk, .rst_n, .debug_req_i(debug_req), .debug_gnt_o(debug_gnt),
    .debug_rvalid_o(debug_rvalid), .debug_addr_i(debug_addr), .debug_we_i(debug_we),
    .debug_wdata_i(debug_wdata), .debug_rdata_o(debug_rdata), .debug_halt_i(debug_halt),
    .debug_resume_i(debug_resume), .debug_halted_o(debug_halted), .settings_o(settings),
    .trap_i(trap), .exc_cause_i(exc_cause), .stall_o(stall), .dbg_req_o(dbg_req),
    .dbg_ack_i(dbg_ack), .regfile_rreq_o(regfile_rreq), .regfile_raddr_o(regfile_raddr),
    .regfile_rdata_i(regfile_rdata), .regfile_wreq_o(regfile_wreq),
    .regfile_waddr_o(regfile_waddr), .regfile_wdata_o(regfile_wdata), .pc_if_i(pc_if),
    .pc_id_i(pc_id), .branch_req_i(branch_req), .branch_addr_i(branch_addr),
    .sleeping_i(sleeping), .jump_req_o(jump_req), .jump_addr_o(jump_addr)
  );

  dbg_core_model u_core (
    .clk, .rst_n, .dbg_req_i(dbg_req), .dbg_ack_o(dbg_ack), .raddr_i(regfile_raddr),
    .rdata_o(regfile_rdata), .wreq_i(regfile_wreq), .waddr_i(regfile_waddr),
    .wdata_i(regfile_wdata), .jump_req_i(jump_req), .jump_addr_i(jump_addr),
    .pc_load_i(pc_load), .pc_val_i(pc_val), .pc_if_o(pc_if), .pc_id_o(pc_id)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else fail_run($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;  // drive point
  endtask

  // --------------------
  // one bus request, data sampled in the rvalid cycle
  task automatic bus_access(input logic wr, input logic [14:0] a, input logic [31:0] d,
                            output logic [31:0] rd, output logic rreq_seen);
    debug_req   = 1'b1;
    debug_we    = wr;
    debug_addr  = a;
    debug_wdata = d;
    #1 check_eq("debug_gnt_o", {31'b0, debug_gnt}, 32'h1);
    @(posedge clk);
    #10;
    debug_req = 1'b0;
    debug_we  = 1'b0;
    check_eq("debug_rvalid_o", {31'b0, debug_rvalid}, 32'h1);
    rd        = debug_rdata;
    rreq_seen = regfile_rreq;
  endtask

  task automatic reg_write(input logic [14:0] a, input logic [31:0] d);
    logic [31:0] rd;
    logic        rq;
    bus_access(1'b1, a, d, rd, rq);
  endtask

  task automatic read_check(input string name, input logic [14:0] a, input logic [31:0] exp);
    logic [31:0] rd;
    logic        rq;
    bus_access(1'b0, a, 32'h0, rd, rq);
    check_eq({"debug_rdata_o ", name}, rd, exp);
  endtask

  // dbg_req held until the core acknowledges
  task automatic wait_halt();
    int n;
    n = 0;
    while (dbg_ack !== 1'b1) begin
      check_eq("dbg_req_o", {31'b0, dbg_req}, 32'h1);
      next_cycle();
      n++;
      if (n > 8) fail_run("core never acknowledged the halt request");
    end
    next_cycle();
    check_eq("debug_halted_o", {31'b0, debug_halted}, 32'h1);
    check_eq("stall_o", {31'b0, stall}, 32'h1);
  endtask

  task automatic resume_core();
    reg_write(A_CTRL, 32'h0);
    check_eq("debug_halted_o", {31'b0, debug_halted}, 32'h0);
    check_eq("stall_o", {31'b0, stall}, 32'h0);
  endtask

  // --------------------
  a_gnt_same_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    debug_req |-> debug_gnt) else fail_run("request not granted in its own cycle");
  a_rvalid_next: assert property (@(posedge clk) disable iff (!rst_n)
    debug_gnt |=> debug_rvalid) else fail_run("rvalid missing one cycle after grant");
  a_rvalid_only: assert property (@(posedge clk) disable iff (!rst_n)
    !debug_gnt |=> !debug_rvalid) else fail_run("rvalid without a grant");
  a_halt_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    dbg_ack |=> debug_halted && stall) else fail_run("core not halted after acknowledge");
  a_wreq_halted: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_wreq |-> debug_halted) else fail_run("register file written while running");

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) fail_run("run did not finish within the cycle limit");
  end

  initial begin
    logic [31:0] rd;
    logic        rq;
    void'($urandom(3));
    {debug_req, debug_we, debug_halt, debug_resume, trap, branch_req} = '0;
    {sleeping, pc_load} = '0;
    debug_addr  = '0;
    debug_wdata = '0;
    exc_cause   = '0;
    branch_addr = '0;
    pc_val      = '0;
    rst_n       = 1'b0;
    repeat (16) @(posedge clk);
    #10;
    rst_n = 1'b1;
    // reset state and cause
    check_eq("gnt/rvalid/dbg_req/stall/halted/rreq/wreq/jump_req",
             {24'b0, debug_gnt, debug_rvalid, dbg_req, stall, debug_halted,
              regfile_rreq, regfile_wreq, jump_req}, 32'h0);
    read_check("CAUSE", A_CAUSE, 32'h0000_001F);
    // register read-back layout
    reg_write(A_IE, 32'h0000_08AC);
    read_check("IE", A_IE, 32'h0000_08AC);
    check_eq("settings_o", {27'b0, settings}, 32'h1E);
    reg_write(A_IE, 32'h0000_0020);  // one elsu bit shows at both
    read_check("IE", A_IE, 32'h0000_00A0);
    check_eq("settings_o", {27'b0, settings}, 32'h04);
    reg_write(A_BP0_DATA, 32'h0000_1235);
    read_check("BP0_DATA", A_BP0_DATA, 32'h0000_1234);
    reg_write(A_BP1_DATA, 32'h0000_8000);
    reg_write(A_BP1_CTRL, 32'h1);
    read_check("BP1_CTRL", A_BP1_CTRL, 32'h0000_0001);
    reg_write(A_CTRL, 32'h1);
    read_check("CTRL", A_CTRL, 32'h0000_0001);
    check_eq("settings_o", {27'b0, settings}, 32'h05);
    // halt from a ctrl write
    reg_write(A_CTRL, 32'h0001_0000);
    wait_halt();
    read_check("CAUSE", A_CAUSE, 32'h0000_001F);
    read_check("CTRL", A_CTRL, 32'h0001_0000);
    // halted only accesses
    reg_write(A_GPR5, 32'hDEAD_BEEF);
    bus_access(1'b0, A_GPR5, 32'h0, rd, rq);
    check_eq("debug_rdata_o GPR5", rd, 32'hDEAD_BEEF);
    check_eq("regfile_rreq_o", {31'b0, rq}, 32'h1);
    read_check("NPC", A_NPC, 32'h0000_0200);
    read_check("PPC", A_PPC, 32'h0000_01FC);
    reg_write(A_NPC, 32'h0000_0400);
    check_eq("jump_req_o", {31'b0, jump_req}, 32'h1);
    check_eq("jump_addr_o", jump_addr, 32'h0000_0400);
    read_check("NPC", A_NPC, 32'h0000_0400);
    resume_core();
    // running, gpr and npc writes are dropped
    reg_write(A_GPR5, 32'h0BAD_F00D);
    reg_write(A_NPC, 32'h0000_0800);
    check_eq("jump_req_o", {31'b0, jump_req}, 32'h0);
    bus_access(1'b0, A_GPR5, 32'h0, rd, rq);
    check_eq("debug_rdata_o GPR5", rd, 32'h0);
    check_eq("regfile_rreq_o", {31'b0, rq}, 32'h0);
    // breakpoint on the fetch pc
    reg_write(A_BP0_DATA, 32'h0000_0480);
    reg_write(A_BP0_CTRL, 32'h1);
    pc_load = 1'b1;
    pc_val  = 32'h0000_0480;
    next_cycle();
    pc_load = 1'b0;
    wait_halt();
    read_check("BP0_CTRL", A_BP0_CTRL, 32'h8000_0001);
    reg_write(A_BP0_CTRL, 32'h0);  // else it halts again on resume
    resume_core();
    // trap with single step, cause bit 5 lands at bit 31
    reg_write(A_CTRL, 32'h1);
    sleeping  = 1'b1;
    trap      = 1'b1;
    exc_cause = 6'h2B;
    next_cycle();
    trap = 1'b0;
    wait_halt();
    read_check("CAUSE", A_CAUSE, 32'h8000_000B);
    read_check("HIT", A_HIT, 32'h0001_0001);
    reg_write(A_HIT, 32'h1);
    read_check("HIT", A_HIT, 32'h0001_0000);
    read_check("GPR5", A_GPR5, 32'hDEAD_BEEF);  // running write left no trace
    resume_core();
    next_cycle();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
src/dbg_pkg.sv
src/dbg_acc_if.sv
src/dbg_ctl_if.sv
src/dbg_bus_decode.sv
src/dbg_regs.sv
src/dbg_halt_ctrl.sv
src/dbg_unit_top.sv
verification/dbg_core_model.sv
verification/tb_dbg_unit.sv
